// File: src/dccm_params.svh
// DCCM sizing
// Address, bank and word widths for the 4 KB banked data memory

`ifndef DCCM_PARAMS_SVH
`define DCCM_PARAMS_SVH

// Byte address into the whole DCCM
`define DCCM_ADDR_W 12

// Word interleaving over the banks
`define DCCM_NUM_BANKS 8
`define DCCM_BANK_W 3

// Byte offset inside a 32-bit word
`define DCCM_BYTE_W 2

// Word index inside one bank, sits above the bank select
`define DCCM_INDEX_W 7
`define DCCM_BANK_DEPTH 128

// 32 data bits plus 7 check bits, carried as opaque data
`define DCCM_DATA_W 39

`endif

// File: src/dccm_pkg.sv
// DCCM types
// Address view, request bundle, per-bank control and read bank selects

`include "dccm_params.svh"

package dccm_pkg;

   // Fields of a byte address, msb first
   typedef struct packed {
      logic [`DCCM_INDEX_W-1:0] index;
      logic [`DCCM_BANK_W-1:0]  bank;
      logic [`DCCM_BYTE_W-1:0]  byte_off;
   } dccm_addr_f_t;

   // One address word, seen flat or split into fields
   typedef union packed {
      logic [`DCCM_ADDR_W-1:0] raw;
      dccm_addr_f_t            f;
   } dccm_addr_u;

   // Load/store request, sampled every cycle
   typedef struct packed {
      logic                    wren;
      logic                    rden;
      dccm_addr_u              wr_addr_lo;
      dccm_addr_u              wr_addr_hi;
      dccm_addr_u              rd_addr_lo;
      dccm_addr_u              rd_addr_hi;
      logic [`DCCM_DATA_W-1:0] wr_data_lo;
      logic [`DCCM_DATA_W-1:0] wr_data_hi;
   } dccm_req_t;

   // Control for one bank
   typedef struct packed {
      logic                     me;
      logic                     we;
      logic [`DCCM_INDEX_W-1:0] index;
      logic [`DCCM_DATA_W-1:0]  wdata;
   } dccm_bank_ctl_t;

   // Banks holding the lo and hi read words
   typedef struct packed {
      logic [`DCCM_BANK_W-1:0] lo_bank;
      logic [`DCCM_BANK_W-1:0] hi_bank;
   } dccm_rd_sel_t;

endpackage

// File: src/dccm_bank_steer.sv
// DCCM bank steering
// Splits a lo/hi request into enable, index and write data for each bank

`timescale 1ns/10ps

`include "dccm_params.svh"

module dccm_bank_steer (
   input  dccm_pkg::dccm_req_t                           req,
   output dccm_pkg::dccm_bank_ctl_t [`DCCM_NUM_BANKS-1:0] bank_ctl,
   output dccm_pkg::dccm_rd_sel_t                        rd_sel,
   output logic                                          rd_sel_valid
);

   localparam logic [`DCCM_BANK_W-1:0] BANK_ONE = 1;

   logic rd_unaligned;
   logic wr_unaligned;

   // Access spans two words when lo and hi land in different banks
   assign rd_unaligned = (req.rd_addr_lo.f.bank != req.rd_addr_hi.f.bank);
   assign wr_unaligned = (req.wr_addr_lo.f.bank != req.wr_addr_hi.f.bank);

   for (genvar i = 0; i < `DCCM_NUM_BANKS; i++) begin : g_bank
      localparam logic [`DCCM_BANK_W-1:0] BANK_ID = i;

      logic wr_hit_lo;
      logic wr_hit_hi;
      logic rd_hit_lo;
      logic rd_hit_hi;
      logic wr_en;
      logic rd_en;
      logic wr_use_hi;
      logic rd_use_hi;

      assign wr_hit_lo = (req.wr_addr_lo.f.bank == BANK_ID);
      assign wr_hit_hi = (req.wr_addr_hi.f.bank == BANK_ID);
      assign rd_hit_lo = (req.rd_addr_lo.f.bank == BANK_ID);
      assign rd_hit_hi = (req.rd_addr_hi.f.bank == BANK_ID);

      assign wr_en = req.wren & (wr_hit_lo | wr_hit_hi);
      assign rd_en = req.rden & (rd_hit_lo | rd_hit_hi);

      // Hi values only for the upper bank of a misaligned access
      assign wr_use_hi = wr_hit_hi & wr_unaligned;
      assign rd_use_hi = rd_hit_hi & rd_unaligned;

      // Bank clock only runs when it is touched
      assign bank_ctl[i].me = wr_en | rd_en;
      assign bank_ctl[i].we = wr_en;

      // Read address wins the index
      assign bank_ctl[i].index = rd_en ?
                                 (rd_use_hi ? req.rd_addr_hi.f.index : req.rd_addr_lo.f.index) :
                                 (wr_use_hi ? req.wr_addr_hi.f.index : req.wr_addr_lo.f.index);

      assign bank_ctl[i].wdata = wr_use_hi ? req.wr_data_hi : req.wr_data_lo;
   end : g_bank

   // Selects travel with the read into the output pipeline
   assign rd_sel.lo_bank = req.rd_addr_lo.f.bank;
   assign rd_sel.hi_bank = req.rd_addr_hi.f.bank;
   assign rd_sel_valid   = req.rden;

   // Request rules, checked once the inputs are known
   always_comb begin
      if (!$isunknown({req.wren, req.rden})) begin
         assert (!(req.wren && req.rden))
            else $error("dccm: write and read requested together");
      end
      if (req.wren === 1'b1 && wr_unaligned) begin
         assert (req.wr_addr_hi.f.bank == req.wr_addr_lo.f.bank + BANK_ONE)
            else $error("dccm: misaligned write hi bank is not lo bank + 1");
      end
      if (req.rden === 1'b1 && rd_unaligned) begin
         assert (req.rd_addr_hi.f.bank == req.rd_addr_lo.f.bank + BANK_ONE)
            else $error("dccm: misaligned read hi bank is not lo bank + 1");
      end
   end

endmodule

// File: src/dccm_bank_ram.sv
// DCCM bank
// Behavioral single-ported RAM with a registered read port and a clock enable

`timescale 1ns/10ps

`include "dccm_params.svh"

module dccm_bank_ram #(
   parameter int DEPTH = `DCCM_BANK_DEPTH,
   parameter int WIDTH = `DCCM_DATA_W
) (
   input  logic                     clk,
   input  logic                     me,
   input  logic                     we,
   input  logic [$clog2(DEPTH)-1:0] index,
   input  logic [WIDTH-1:0]         wdata,
   output logic [WIDTH-1:0]         dout
);

   logic [WIDTH-1:0] mem [DEPTH];

   // Idle bank does nothing, dout keeps the last read word
   always_ff @(posedge clk) begin
      if (me) begin
         if (we) begin
            mem[index] <= wdata;
         end else begin
            dout <= mem[index];
         end
      end
   end

   // Write without the bank clock would be lost
   a_we_needs_me : assert property (@(posedge clk) we |-> me)
      else $error("dccm bank: we high while me low");

endmodule

// File: src/dccm_rd_pipe.sv
// DCCM read pipeline
// Flops all bank outputs one cycle after a read, then picks the lo and hi words

`timescale 1ns/10ps

`include "dccm_params.svh"

module dccm_rd_pipe (
   input  logic                                         clk,
   input  logic                                         arst_n,
   input  dccm_pkg::dccm_rd_sel_t                       rd_sel,
   input  logic                                         rd_sel_valid,
   input  logic [`DCCM_NUM_BANKS-1:0][`DCCM_DATA_W-1:0] bank_dout,
   output logic [`DCCM_DATA_W-1:0]                      rd_data_lo,
   output logic [`DCCM_DATA_W-1:0]                      rd_data_hi
);

   logic                                         rd_valid_q;
   dccm_pkg::dccm_rd_sel_t                       rd_sel_q;
   dccm_pkg::dccm_rd_sel_t                       rd_sel_q2;
   logic [`DCCM_NUM_BANKS-1:0][`DCCM_DATA_W-1:0] bank_dout_q;

   // First stage, lines up with the bank read
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_valid_q <= 1'b0;
         rd_sel_q   <= '0;
      end else begin
         rd_valid_q <= rd_sel_valid;
         if (rd_sel_valid) begin
            rd_sel_q <= rd_sel;
         end
      end
   end

   // Second stage
   // Data and selects only move on a read, so the outputs hold in between
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_sel_q2   <= '0;
         bank_dout_q <= '0;
      end else if (rd_valid_q) begin
         rd_sel_q2   <= rd_sel_q;
         bank_dout_q <= bank_dout;
      end
   end

   // Lo and hi word mux
   assign rd_data_lo = bank_dout_q[rd_sel_q2.lo_bank];
   assign rd_data_hi = bank_dout_q[rd_sel_q2.hi_bank];

   a_sel_known : assert property (@(posedge clk) disable iff (!arst_n)
                                  !$isunknown(rd_sel_q2))
      else $error("dccm read pipe: output bank select is unknown");

endmodule

// File: src/dccm_mem.sv
// DCCM top
// 4 KB data memory in 8 word-interleaved banks, two-cycle read latency
// A request may cover two neighboring words through its lo and hi addresses

`timescale 1ns/10ps

`include "dccm_params.svh"

module dccm_mem (
   input  logic                    clk,
   input  logic                    arst_n,
   input  dccm_pkg::dccm_req_t     req,
   output logic [`DCCM_DATA_W-1:0] rd_data_lo,
   output logic [`DCCM_DATA_W-1:0] rd_data_hi
);

   dccm_pkg::dccm_bank_ctl_t [`DCCM_NUM_BANKS-1:0] bank_ctl;
   dccm_pkg::dccm_rd_sel_t                        rd_sel;
   logic                                          rd_sel_valid;

   logic [`DCCM_NUM_BANKS-1:0][`DCCM_DATA_W-1:0] bank_dout;

   // Address decode and per-bank steering
   dccm_bank_steer dccm_bank_steer_inst (
      .req          (req),
      .bank_ctl     (bank_ctl),
      .rd_sel       (rd_sel),
      .rd_sel_valid (rd_sel_valid)
   );

   // Banks, one word per bank per cycle
   for (genvar i = 0; i < `DCCM_NUM_BANKS; i++) begin : g_bank
      dccm_bank_ram #(
         .DEPTH (`DCCM_BANK_DEPTH),
         .WIDTH (`DCCM_DATA_W)
      ) dccm_bank_ram_inst (
         .clk   (clk),
         .me    (bank_ctl[i].me),
         .we    (bank_ctl[i].we),
         .index (bank_ctl[i].index),
         .wdata (bank_ctl[i].wdata),
         .dout  (bank_dout[i])
      );
   end : g_bank

   // Bank output flop and lo/hi word select
   dccm_rd_pipe dccm_rd_pipe_inst (
      .clk          (clk),
      .arst_n       (arst_n),
      .rd_sel       (rd_sel),
      .rd_sel_valid (rd_sel_valid),
      .bank_dout    (bank_dout),
      .rd_data_lo   (rd_data_lo),
      .rd_data_hi   (rd_data_hi)
   );

endmodule

// File: bench/dccm_mem_tb.sv
// DCCM testbench
// Directed tests of the banked data memory against a shadow word model

`timescale 1ns/10ps

`include "dccm_params.svh"

module dccm_mem_tb;

   typedef logic [`DCCM_ADDR_W-1:0] addr_t;
   typedef logic [`DCCM_DATA_W-1:0] word_t;

   localparam int NUM_WORDS  = 1 << (`DCCM_ADDR_W - `DCCM_BYTE_W);
   localparam int RAND_OPS   = 200;
   // Misaligned pairs from bank 3 into bank 4 and from bank 7 wrapping into bank 0
   localparam int MIS_WORD_A = 20 * 8 + 3;
   localparam int MIS_WORD_B = 40 * 8 + 7;
   // All tests together take under 1000 cycles
   localparam int TIMEOUT_CYCLES = 4000;

   logic                clk;
   logic                arst_n;
   dccm_pkg::dccm_req_t req;
   word_t               rd_data_lo;
   word_t               rd_data_hi;

   // Shadow copy of the memory with one entry per 32-bit word
   word_t model [NUM_WORDS];
   bit    written [NUM_WORDS];

   int errors      = 0;
   int checks      = 0;
   int cycle_count = 0;

   dccm_mem dccm_mem_inst (
      .clk        (clk),
      .arst_n     (arst_n),
      .req        (req),
      .rd_data_lo (rd_data_lo),
      .rd_data_hi (rd_data_hi)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
         $display("Testbench failed");
         $finish;
      end
   end

   function automatic addr_t byte_addr(int word, int off);
      return addr_t'(word * 4 + off);
   endfunction

   function automatic int word_of(addr_t a);
      return int'(a) / 4;
   endfunction

   // One word per bank at its own index
   function automatic int aligned_test_word(int bank);
      return (5 + bank * 3) * 8 + bank;
   endfunction

   function automatic word_t rand_word();
      logic [63:0] r;
      r = {$urandom(), $urandom()};
      return r[`DCCM_DATA_W-1:0];
   endfunction

   function automatic dccm_pkg::dccm_req_t make_read(addr_t lo, addr_t hi);
      dccm_pkg::dccm_req_t r;
      r               = '0;
      r.rden          = 1'b1;
      r.rd_addr_lo.raw = lo;
      r.rd_addr_hi.raw = hi;
      return r;
   endfunction

   function automatic dccm_pkg::dccm_req_t make_write(addr_t lo, addr_t hi,
                                                      word_t dlo, word_t dhi);
      dccm_pkg::dccm_req_t r;
      r                = '0;
      r.wren           = 1'b1;
      r.wr_addr_lo.raw = lo;
      r.wr_addr_hi.raw = hi;
      r.wr_data_lo     = dlo;
      r.wr_data_hi     = dhi;
      return r;
   endfunction

   task automatic check_value(string test, word_t expected, word_t actual);
      checks++;
      if (actual !== expected) begin
         $display("ERR %s: expected %h, actual %h", test, expected, actual);
         errors++;
      end
   endtask

   task automatic drive_req(dccm_pkg::dccm_req_t r);
      @(posedge clk);
      req <= r;
   endtask

   task automatic drive_idle();
      @(posedge clk);
      req <= '0;
   endtask

   task automatic write_words(addr_t lo, bit mis, word_t dlo, word_t dhi);
      addr_t hi;
      hi = mis ? lo + addr_t'(4) : lo;
      drive_req(make_write(lo, hi, dlo, dhi));
      drive_idle();
      model[word_of(lo)]   = dlo;
      written[word_of(lo)] = 1'b1;
      if (mis) begin
         model[word_of(hi)]   = dhi;
         written[word_of(hi)] = 1'b1;
      end
   endtask

   // Data is due two edges after the read is driven
   task automatic read_check(string test, addr_t lo, bit mis);
      addr_t hi;
      word_t exp_lo;
      word_t exp_hi;
      hi     = mis ? lo + addr_t'(4) : lo;
      exp_lo = model[word_of(lo)];
      exp_hi = model[word_of(hi)];
      drive_req(make_read(lo, hi));
      drive_idle();
      @(posedge clk);
      @(negedge clk);
      check_value({test, " lo"}, exp_lo, rd_data_lo);
      check_value({test, " hi"}, exp_hi, rd_data_hi);
   endtask

   task automatic reset_values();
      @(negedge clk);
      check_value("reset lo", '0, rd_data_lo);
      check_value("reset hi", '0, rd_data_hi);
   endtask

   task automatic aligned_access();
      for (int b = 0; b < `DCCM_NUM_BANKS; b++) begin
         write_words(byte_addr(aligned_test_word(b), 0), 1'b0, rand_word(), rand_word());
      end
      for (int b = 0; b < `DCCM_NUM_BANKS; b++) begin
         read_check($sformatf("aligned bank %0d", b), byte_addr(aligned_test_word(b), 0),
                    1'b0);
      end
   endtask

   task automatic misaligned_access();
      write_words(byte_addr(MIS_WORD_A, 2), 1'b1, rand_word(), rand_word());
      read_check("misaligned a lo word", byte_addr(MIS_WORD_A, 0), 1'b0);
      read_check("misaligned a hi word", byte_addr(MIS_WORD_A + 1, 0), 1'b0);
      write_words(byte_addr(MIS_WORD_B, 1), 1'b1, rand_word(), rand_word());
      read_check("wrap lo word", byte_addr(MIS_WORD_B, 0), 1'b0);
      read_check("wrap hi word", byte_addr(MIS_WORD_B + 1, 0), 1'b0);
      read_check("misaligned a pair", byte_addr(MIS_WORD_A, 2), 1'b1);
      read_check("wrap pair", byte_addr(MIS_WORD_B, 1), 1'b1);
   endtask

   task automatic back_to_back_reads();
      addr_t lo_q [8];
      addr_t hi_q [8];
      word_t exp_lo [8];
      word_t exp_hi [8];
      int    w;
      for (int k = 0; k < 8; k++) begin
         if (k == 3 || k == 6) begin
            w       = (k == 3) ? MIS_WORD_A : MIS_WORD_B;
            lo_q[k] = byte_addr(w, 2);
            hi_q[k] = lo_q[k] + addr_t'(4);
         end else begin
            w       = aligned_test_word(k);
            lo_q[k] = byte_addr(w, 0);
            hi_q[k] = lo_q[k];
         end
         exp_lo[k] = model[word_of(lo_q[k])];
         exp_hi[k] = model[word_of(hi_q[k])];
      end
      // Read c is issued in pass c and lands in pass c + 2
      for (int c = 0; c < 10; c++) begin
         @(posedge clk);
         if (c < 8) begin
            req <= make_read(lo_q[c], hi_q[c]);
         end else begin
            req <= '0;
         end
         @(negedge clk);
         if (c >= 2) begin
            check_value($sformatf("back_to_back %0d lo", c - 2), exp_lo[c-2], rd_data_lo);
            check_value($sformatf("back_to_back %0d hi", c - 2), exp_hi[c-2], rd_data_hi);
         end
      end
   endtask

   task automatic output_hold();
      int    word;
      addr_t a;
      word_t held;
      word = aligned_test_word(2);
      a    = byte_addr(word, 0);
      held = model[word];
      read_check("hold first read", a, 1'b0);
      repeat (3) begin
         @(posedge clk);
         @(negedge clk);
         check_value("hold idle lo", held, rd_data_lo);
         check_value("hold idle hi", held, rd_data_hi);
      end
      // Outputs still show the old read after the word is rewritten
      write_words(a, 1'b0, rand_word(), rand_word());
      write_words(byte_addr(MIS_WORD_A, 2), 1'b1, rand_word(), rand_word());
      @(negedge clk);
      check_value("hold write lo", held, rd_data_lo);
      check_value("hold write hi", held, rd_data_hi);
      read_check("hold reread", a, 1'b0);
   endtask

   task automatic random_traffic();
      int    word;
      int    hi_word;
      int    off;
      bit    mis;
      bit    do_read;
      addr_t lo;
      for (int n = 0; n < RAND_OPS; n++) begin
         word    = int'($urandom_range(0, NUM_WORDS - 1));
         mis     = ($urandom_range(0, 1) == 1);
         do_read = ($urandom_range(0, 1) == 1);
         off     = mis ? int'($urandom_range(1, 3)) : 0;
         hi_word = mis ? (word + 1) % NUM_WORDS : word;
         lo      = byte_addr(word, off);
         // Reads of words not yet written turn into writes since their data is undefined
         if (do_read && written[word] && written[hi_word]) begin
            read_check($sformatf("random %0d", n), lo, mis);
         end else begin
            write_words(lo, mis, rand_word(), rand_word());
         end
      end
   endtask

   initial begin
      void'($urandom(25086));
      req      = '0;
      arst_n   = 1'b0;
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
      reset_values();
      aligned_access();
      misaligned_access();
      back_to_back_reads();
      output_hold();
      random_traffic();
      repeat (2) @(posedge clk);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: vlog.f
+incdir+src
src/dccm_pkg.sv
src/dccm_bank_steer.sv
src/dccm_bank_ram.sv
src/dccm_rd_pipe.sv
src/dccm_mem.sv
bench/dccm_mem_tb.sv

// File: Makefile
# Verilator build and run of the DCCM testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= dccm_mem_tb
FILELIST  ?= vlog.f

SIM       = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the Verilator build directory"

$(SIM): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
